// ==== Makefile ====
# Verilator simulation of the OBI bus testbench

SIM      ?= verilator
VFLAGS   ?= --binary --timing -j 0
TOP      := tb_mcu_bus
FILELIST := sim.f
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/addr_decode.sv ====
/*
 * Address decoder mapping a bus address to a slave port index
 */
`timescale 1ns/1ps

module addr_decode
  import obi_xbar_pkg::*;
(
  input  logic [31:0]                  addr_i,
  input  addr_rule_t [NRULES-1:0]      addr_map_i,
  input  logic [LOG_NSLAVE-1:0]        default_idx_i,
  output logic [LOG_NSLAVE-1:0]        idx_o
);

  // Walk the rules from last to first so the lowest matching rule wins
  always_comb begin
    idx_o = default_idx_i;
    for (int r = int'(NRULES) - 1; r >= 0; r--) begin
      if ((addr_i >= addr_map_i[r].start_addr) && (addr_i < addr_map_i[r].end_addr)) begin
        idx_o = addr_map_i[r].idx;
      end
    end
  end

endmodule : addr_decode

// ==== hw/error_slave.sv ====
/*
 * Error slave that answers with the faulting address
 */
`timescale 1ns/1ps

module error_slave
  import obi_xbar_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  obi_req_t  req_i,
  output obi_resp_t resp_o
);

  logic [31:0] addr_q;
  logic        rvalid_q;

  // Writes are dropped, only the address is kept
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      addr_q <= req_i.addr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.rdata  = addr_q;

endmodule : error_slave

// ==== hw/mcu_bus_top.sv ====
/*
 * Bus top level with system crossbar, two SRAM banks and error slave
 */
`timescale 1ns/1ps

module mcu_bus_top
  import obi_xbar_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  obi_req_t  [NMASTER-1:0] master_req_i,
  output obi_resp_t [NMASTER-1:0] master_resp_o
);

  obi_req_t  [NSLAVE-1:0] slave_req;
  obi_resp_t [NSLAVE-1:0] slave_resp;

  system_xbar u_system_xbar (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .master_req_i  (master_req_i),
    .master_resp_o (master_resp_o),
    .slave_req_o   (slave_req),
    .slave_resp_i  (slave_resp)
  );

  sram_bank u_ram0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (slave_req[RAM0_IDX]),
    .resp_o  (slave_resp[RAM0_IDX])
  );

  sram_bank u_ram1 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (slave_req[RAM1_IDX]),
    .resp_o  (slave_resp[RAM1_IDX])
  );

  error_slave u_error_slave (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (slave_req[ERROR_IDX]),
    .resp_o  (slave_resp[ERROR_IDX])
  );

endmodule : mcu_bus_top

// ==== hw/obi_xbar_pkg.sv ====
/*
 * OBI bus request and response structs, crossbar sizes,
 * address rule type and the system address map
 */
package obi_xbar_pkg;

  // Crossbar sizes
  localparam int unsigned NMASTER     = 3;
  localparam int unsigned NSLAVE      = 3;
  localparam int unsigned LOG_NSLAVE  = 2;
  localparam int unsigned LOG_NMASTER = 2;

  // Slave port indices
  localparam int unsigned RAM0_IDX  = 0;
  localparam int unsigned RAM1_IDX  = 1;
  localparam int unsigned ERROR_IDX = 2;

  // SRAM bank geometry, 1 KiB per bank
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned BANK_AW    = 8;

  // Address map, end addresses are exclusive
  localparam logic [31:0] RAM0_BASE = 32'h0000_0000;
  localparam logic [31:0] RAM1_BASE = 32'h0000_0400;
  localparam logic [31:0] RAM_END   = 32'h0000_0800;

  // One rule per SRAM bank, everything else falls to the error slave
  localparam int unsigned NRULES = 2;

  // Master to slave request
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  // Slave to master response
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  // Address range mapped to one slave port
  typedef struct packed {
    logic [LOG_NSLAVE-1:0] idx;
    logic [31:0]           start_addr;
    logic [31:0]           end_addr;
  } addr_rule_t;

  localparam addr_rule_t [NRULES-1:0] XBAR_ADDR_RULES = '{
    0: '{
      idx:        LOG_NSLAVE'(RAM0_IDX),
      start_addr: RAM0_BASE,
      end_addr:   RAM1_BASE
    },
    1: '{
      idx:        LOG_NSLAVE'(RAM1_IDX),
      start_addr: RAM1_BASE,
      end_addr:   RAM_END
    }
  };

endpackage : obi_xbar_pkg

// ==== hw/rr_arbiter.sv ====
/*
 * Round-robin arbiter for one slave port of the crossbar
 */
`timescale 1ns/1ps

module rr_arbiter
  import obi_xbar_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic [NMASTER-1:0] req_i,
  output logic [NMASTER-1:0] gnt_o
);

  logic [LOG_NMASTER-1:0] ptr_q;
  logic [LOG_NMASTER-1:0] win_idx;
  logic                   found;

  // Cyclic search for the first requester, starting at the pointer
  always_comb begin
    gnt_o   = '0;
    win_idx = '0;
    found   = 1'b0;
    for (int unsigned k = 0; k < NMASTER; k++) begin
      int unsigned cand;
      cand = (int'(ptr_q) + k) % NMASTER;
      if (!found && req_i[cand]) begin
        found       = 1'b1;
        win_idx     = LOG_NMASTER'(cand);
        gnt_o[cand] = 1'b1;
      end
    end
  end

  // Pointer moves just past the master that won
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (found) begin
      if (win_idx == LOG_NMASTER'(NMASTER - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= win_idx + 1'b1;
      end
    end
  end

endmodule : rr_arbiter

// ==== hw/sram_bank.sv ====
/*
 * Single-cycle word SRAM bank with byte-enable writes
 */
`timescale 1ns/1ps

module sram_bank
  import obi_xbar_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  obi_req_t  req_i,
  output obi_resp_t resp_o
);

  logic [31:0]        mem [BANK_WORDS];
  logic [BANK_AW-1:0] word_idx;
  logic [31:0]        rdata_q;
  logic               rvalid_q;

  // Word offset inside the bank, above the byte lane bits
  assign word_idx = req_i.addr[BANK_AW+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int unsigned b = 0; b < 4; b++) begin
          if (req_i.be[b]) begin
            mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  // Always ready
  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.rdata  = rdata_q;

endmodule : sram_bank

// ==== hw/system_xbar.sv ====
/*
 * System crossbar with one address decoder per master port
 */
`timescale 1ns/1ps

module system_xbar
  import obi_xbar_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  obi_req_t  [NMASTER-1:0] master_req_i,
  output obi_resp_t [NMASTER-1:0] master_resp_o,
  output obi_req_t  [NSLAVE-1:0]  slave_req_o,
  input  obi_resp_t [NSLAVE-1:0]  slave_resp_i
);

  logic [NMASTER-1:0][LOG_NSLAVE-1:0] port_sel;
  logic [NMASTER-1:0]                 master_req;

  // Unmapped addresses go to the error slave
  for (genvar m = 0; m < NMASTER; m++) begin : gen_addr_decoders
    addr_decode u_addr_decode (
      .addr_i        (master_req_i[m].addr),
      .addr_map_i    (XBAR_ADDR_RULES),
      .default_idx_i (LOG_NSLAVE'(ERROR_IDX)),
      .idx_o         (port_sel[m])
    );
    assign master_req[m] = master_req_i[m].req;
  end

  xbar u_xbar (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (master_req),
    .port_sel_i (port_sel),
    .mreq_i     (master_req_i),
    .mresp_o    (master_resp_o),
    .sreq_o     (slave_req_o),
    .sresp_i    (slave_resp_i)
  );

endmodule : system_xbar

// ==== hw/xbar.sv ====
/*
 * Crossbar core with one arbiter and request mux per slave
 * and registered response routing per master
 */
`timescale 1ns/1ps

module xbar
  import obi_xbar_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic [NMASTER-1:0]                   req_i,
  input  logic [NMASTER-1:0][LOG_NSLAVE-1:0]   port_sel_i,
  input  obi_req_t [NMASTER-1:0]               mreq_i,
  output obi_resp_t [NMASTER-1:0]              mresp_o,
  output obi_req_t [NSLAVE-1:0]                sreq_o,
  input  obi_resp_t [NSLAVE-1:0]               sresp_i
);

  // Per slave, which masters want it and which one won
  logic [NSLAVE-1:0][NMASTER-1:0] slave_reqs;
  logic [NSLAVE-1:0][NMASTER-1:0] arb_gnt;

  logic [NMASTER-1:0]                 master_gnt;
  logic [NMASTER-1:0]                 valid_q;
  logic [NMASTER-1:0][LOG_NSLAVE-1:0] sel_q;

  always_comb begin
    for (int unsigned s = 0; s < NSLAVE; s++) begin
      for (int unsigned m = 0; m < NMASTER; m++) begin
        slave_reqs[s][m] = req_i[m] && (port_sel_i[m] == LOG_NSLAVE'(s));
      end
    end
  end

  for (genvar s = 0; s < NSLAVE; s++) begin : gen_arbiters
    rr_arbiter u_rr_arbiter (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (slave_reqs[s]),
      .gnt_o   (arb_gnt[s])
    );
  end

  // Forward the winning request, idle slaves see an all-zero request
  always_comb begin
    for (int unsigned s = 0; s < NSLAVE; s++) begin
      sreq_o[s] = '0;
      for (int unsigned m = 0; m < NMASTER; m++) begin
        if (arb_gnt[s][m]) begin
          sreq_o[s] = mreq_i[m];
        end
      end
      sreq_o[s].req = |arb_gnt[s];
    end
  end

  // Master is granted when its arbiter picks it and the slave accepts
  always_comb begin
    master_gnt = '0;
    for (int unsigned m = 0; m < NMASTER; m++) begin
      for (int unsigned s = 0; s < NSLAVE; s++) begin
        if (arb_gnt[s][m] && sresp_i[s].gnt) begin
          master_gnt[m] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= master_gnt;
    end
  end

  // Remember which slave answers next cycle
  always_ff @(posedge clk_i) begin
    for (int unsigned m = 0; m < NMASTER; m++) begin
      if (master_gnt[m]) begin
        sel_q[m] <= port_sel_i[m];
      end
    end
  end

  // Slave rvalid is not used, valid comes from the registered grant
  for (genvar m = 0; m < NMASTER; m++) begin : gen_resp
    assign mresp_o[m].gnt    = master_gnt[m];
    assign mresp_o[m].rvalid = valid_q[m];
    assign mresp_o[m].rdata  = sresp_i[sel_q[m]].rdata;
  end

endmodule : xbar

// ==== sim.f ====
hw/obi_xbar_pkg.sv
hw/addr_decode.sv
hw/rr_arbiter.sv
hw/xbar.sv
hw/system_xbar.sv
hw/sram_bank.sv
hw/error_slave.sv
hw/mcu_bus_top.sv
verif/tb_mcu_bus.sv

// ==== verif/tb_mcu_bus.sv ====
/*
 * Testbench for the OBI bus top level with three concurrent masters,
 * a reference memory model, response checker and cycle timeout
 */
`timescale 1ns/1ps

module tb_mcu_bus
  import obi_xbar_pkg::*;
();

  localparam logic [31:0] SEED = 32'hbd7b_60b1;

  // Each test phase runs all masters in parallel
  localparam int PH_FAIR    = 0;
  localparam int PH_FILL    = 1;
  localparam int PH_REGION  = 2;
  localparam int PH_BYTE_EN = 3;
  localparam int PH_ERROR   = 4;
  localparam int PH_PAR     = 5;
  localparam int PH_RAND    = 6;

  // Transactions per master in each phase
  localparam int FAIR_TXNS    = 6;
  localparam int REGION_WORDS = 8;
  localparam int BE_PATTERNS  = 6;
  localparam int ERR_TXNS     = 6;
  localparam int PAR_ROUNDS   = 6;
  localparam int RAND_TXNS    = 300;

  localparam int TOTAL_TXNS = 2 * BANK_WORDS + NMASTER * (FAIR_TXNS + 4 * REGION_WORDS +
                              1 + 2 * BE_PATTERNS + ERR_TXNS + PAR_ROUNDS + RAND_TXNS);
  localparam int TIMEOUT_CYCLES = 4 * TOTAL_TXNS + 100;

  localparam logic [3:0] BE_PAT [BE_PATTERNS] = '{
    4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0101, 4'b1010
  };

  logic                    clk_i;
  logic                    rst_n_i;
  obi_req_t  [NMASTER-1:0] master_req;
  obi_resp_t [NMASTER-1:0] master_resp;

  // Word-indexed reference model of both banks
  logic [31:0] model_mem [2*BANK_WORDS];
  logic [31:0] rng_state [NMASTER];

  // Checker state for the response due in the next cycle
  obi_resp_t [NMASTER-1:0] pend_resp;
  logic [NMASTER-1:0]      pend_valid;
  logic [NMASTER-1:0]      pend_read;
  logic [NMASTER-1:0]      accepted;
  obi_resp_t               exp_resp;

  logic                  fair_on;
  logic [LOG_NSLAVE-1:0] grant_log [$];
  int                    last_gnt [NMASTER];
  int                    par_gnt [NMASTER][PAR_ROUNDS];
  int                    cycle_cnt = 0;

  mcu_bus_top DUT (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .master_req_i  (master_req),
    .master_resp_o (master_resp)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand(input int m);
    rng_state[m] = rng_state[m] * 32'd1664525 + 32'd1013904223;
    return rng_state[m];
  endfunction

  // Fill data mixes every address bit
  function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
  endfunction

  // Unmapped reads return their own address
  function automatic logic [31:0] expected_rdata(input logic [31:0] addr);
    if (addr < RAM_END) begin
      return model_mem[addr[10:2]];
    end
    return addr;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_resp(input int m, input obi_resp_t got, input obi_resp_t exp,
                            input logic check_data);
    if (got.rvalid !== exp.rvalid) begin
      abort_run($sformatf("Mismatch at %0t: master %0d rvalid %b, expected %b",
                          $time, m, got.rvalid, exp.rvalid));
    end else if (check_data && (got.rdata !== exp.rdata)) begin
      abort_run($sformatf("Mismatch at %0t: master %0d rdata %h, expected %h",
                          $time, m, got.rdata, exp.rdata));
    end
  endtask

  task automatic check_idx(input logic [LOG_NSLAVE-1:0] got, input logic [LOG_NSLAVE-1:0] exp,
                           input int n);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: grant %0d went to master %0d, expected %0d",
                          $time, n, got, exp));
    end
  endtask

  // One OBI transfer that starts and ends on a falling edge
  task automatic do_access(input int m, input logic we, input logic [3:0] be,
                           input logic [31:0] addr, input logic [31:0] wdata);
    obi_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.be    = be;
    r.addr  = addr;
    r.wdata = wdata;
    master_req[m] = r;
    @(posedge clk_i);
    while (!master_resp[m].gnt) begin
      @(posedge clk_i);
    end
    last_gnt[m] = cycle_cnt;
    @(negedge clk_i);
    master_req[m] = '0;
  endtask

  task automatic master_phase(input int m, input int phase);
    logic [31:0] a;
    logic [31:0] r;
    int          s;
    case (phase)
      PH_FAIR: begin
        // Each write is read back from bank 0
        for (int i = 0; i < FAIR_TXNS; i++) begin
          a = RAM0_BASE + 32'h100 + 32'(m * 32) + 32'(i / 2 * 4);
          do_access(m, (i % 2) == 0, 4'hf, a, next_rand(m));
        end
      end
      PH_FILL: begin
        for (int w = m; w < 2 * BANK_WORDS; w += NMASTER) begin
          a = 32'(w) << 2;
          do_access(m, 1'b1, 4'hf, a, fill_pattern(a));
        end
      end
      PH_REGION: begin
        for (int pass = 0; pass < 2; pass++) begin
          for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < REGION_WORDS; i++) begin
              a = ((b == 0) ? RAM0_BASE : RAM1_BASE) + 32'h200 +
                  32'(m * REGION_WORDS * 4) + 32'(i * 4);
              do_access(m, pass == 0, 4'hf, a, next_rand(m));
            end
          end
        end
      end
      PH_BYTE_EN: begin
        a = RAM1_BASE + 32'h280 + 32'(m * 4);
        do_access(m, 1'b1, 4'hf, a, next_rand(m));
        for (int i = 0; i < BE_PATTERNS; i++) begin
          do_access(m, 1'b1, BE_PAT[i], a, next_rand(m));
          do_access(m, 1'b0, 4'hf, a, '0);
        end
      end
      PH_ERROR: begin
        // Unmapped writes land on addresses that alias bank words
        a = RAM_END + m * 32'h404;
        r = 32'hffff_fffc - m * 32'h100;
        do_access(m, 1'b1, 4'hf, a, next_rand(m));
        do_access(m, 1'b1, 4'hf, r, next_rand(m));
        do_access(m, 1'b0, 4'hf, a, '0);
        do_access(m, 1'b0, 4'hf, r, '0);
        do_access(m, 1'b0, 4'hf, a & 32'h7ff, '0);
        do_access(m, 1'b0, 4'hf, r & 32'h7ff, '0);
      end
      PH_PAR: begin
        for (int rnd = 0; rnd < PAR_ROUNDS; rnd++) begin
          s = (m + rnd / 2) % NSLAVE;
          a = (s == 0) ? RAM0_BASE : ((s == 1) ? RAM1_BASE : RAM_END);
          a = a + 32'h300 + 32'(m * 4);
          do_access(m, (rnd % 2) == 0, 4'hf, a, next_rand(m));
          par_gnt[m][rnd] = last_gnt[m];
        end
      end
      default: begin
        for (int i = 0; i < RAND_TXNS; i++) begin
          r = next_rand(m);
          if (r[13:12] == 2'b11) begin
            a = {r[31:2], 2'b00};
          end else begin
            a = {21'd0, r[10:2], 2'b00};
          end
          if (r[16]) begin
            @(negedge clk_i);
          end
          do_access(m, r[17], r[21:18], a, next_rand(m));
        end
      end
    endcase
  endtask

  task automatic run_phase(input int phase);
    fork
      master_phase(0, phase);
      master_phase(1, phase);
      master_phase(2, phase);
    join
  endtask

  task automatic check_parallel_grants();
    for (int rnd = 0; rnd < PAR_ROUNDS; rnd++) begin
      for (int m = 1; m < NMASTER; m++) begin
        if (par_gnt[m][rnd] != par_gnt[0][rnd]) begin
          abort_run($sformatf("Masters on different slaves were not granted together in round %0d",
                              rnd));
        end
      end
    end
  endtask

  // Response checker and model update at every accepted edge
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_valid = '0;
    end else begin
      for (int m = 0; m < NMASTER; m++) begin
        exp_resp        = pend_resp[m];
        exp_resp.rvalid = pend_valid[m];
        check_resp(m, master_resp[m], exp_resp, pend_valid[m] && pend_read[m]);
        accepted[m] = master_req[m].req && master_resp[m].gnt;
        if (accepted[m]) begin
          pend_resp[m].rdata = expected_rdata(master_req[m].addr);
          pend_read[m]       = !master_req[m].we;
        end
        pend_valid[m] = accepted[m];
      end
      // Writes go in after reads since a bank serves one master per cycle
      for (int m = 0; m < NMASTER; m++) begin
        if (accepted[m] && fair_on) begin
          grant_log.push_back(LOG_NSLAVE'(m));
        end
        if (accepted[m] && master_req[m].we && (master_req[m].addr < RAM_END)) begin
          for (int b = 0; b < 4; b++) begin
            if (master_req[m].be[b]) begin
              model_mem[master_req[m].addr[10:2]][8*b +: 8] = master_req[m].wdata[8*b +: 8];
            end
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  initial begin
    clk_i      = 1'b0;
    rst_n_i    = 1'b0;
    master_req = '0;
    pend_resp  = '0;
    pend_valid = '0;
    pend_read  = '0;
    fair_on    = 1'b0;
    for (int m = 0; m < NMASTER; m++) begin
      rng_state[m] = SEED + 32'(m);
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Contention on bank 0 straight after reset
    @(negedge clk_i);
    fair_on = 1'b1;
    run_phase(PH_FAIR);
    fair_on = 1'b0;
    for (int n = 0; n < grant_log.size(); n++) begin
      check_idx(grant_log[n], LOG_NSLAVE'(n % NMASTER), n);
    end

    for (int p = PH_FILL; p <= PH_RAND; p++) begin
      @(negedge clk_i);
      run_phase(p);
      if (p == PH_PAR) begin
        check_parallel_grants();
      end
    end

    // Let the last responses reach the checker
    @(negedge clk_i);
    repeat (2) @(posedge clk_i);
    $display("all tests passed");
    $finish;
  end

endmodule : tb_mcu_bus
